//--- logic/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// divider wraps after this count
// one tick per 51 hwclk cycles
`define TICK_TERMINAL 50

// sram depth in 32-bit words
`define SRAM_WORDS 256

// words per display frame, read from word 0 upward
`define FRAME_WORDS 8

`endif

//--- logic/wb_pkg.sv
package wb_pkg;

  // bus payload and addressing shared by the engine and the sram

  // one full bus word
  // every transfer moves all four bytes, no byte selects
  typedef logic [31:0] wbWord_t;

  // byte address on the bus
  // word index starts at bit 2
  typedef logic [31:0] wbAddr_t;

  // bits 1:0 always zero for word access
  // sram only looks at the low index bits

endpackage

//--- logic/disp_pkg.sv
package disp_pkg;

  // frame engine sequencing
  // IDLE also covers byte packing and button handling
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    SHIFT,
    NEXT
  } engState_t;

  // count of bits already clocked out by the spi shifter
  // must be able to hold 32
  typedef logic [5:0] bitCount_t;

endpackage

//--- logic/clkDivider.sv
`timescale 1ns/10ps
`include "board_settings.svh"

module clkDivider (
  input  logic hwclk,
  input  logic reset,
  output logic tick_o
);

  // position inside the current tick period
  logic [8:0] count;

  // tick is a clock enable, no derived clock
  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      count  <= '0;
      tick_o <= 1'b0;
    end else if (count == 9'(`TICK_TERMINAL)) begin
      // period end, wrap and pulse
      count  <= '0;
      tick_o <= 1'b1;
    end else begin
      count  <= count + 9'd1;
      // pulse lasts a single hwclk cycle
      tick_o <= 1'b0;
    end
  end

endmodule

//--- logic/sramWb.sv
`timescale 1ns/10ps
`include "board_settings.svh"

module sramWb (
  input  logic            hwclk,
  input  logic            reset,
  input  logic            tick_i,
  input  logic            cyc_i,
  input  logic            stb_i,
  input  logic            we_i,
  input  wb_pkg::wbAddr_t adr_i,
  input  wb_pkg::wbWord_t dat_i,
  output logic            ack_o,
  output wb_pkg::wbWord_t dat_o
);
  import wb_pkg::*;

  // index bits above the byte offset
  localparam int IDX_W = $clog2(`SRAM_WORDS);

  wbWord_t          mem [`SRAM_WORDS];
  logic [IDX_W-1:0] wordIdx;
  // live request from the master
  logic             reqValid;
  // request seen on a tick, ack due on the next one
  logic             pend;
  // already acked, wait for stb to drop
  logic             served;

  assign reqValid = cyc_i && stb_i;
  assign wordIdx  = adr_i[IDX_W+1:2];
  // ack only in the tick cycle so the master sees it
  assign ack_o    = pend && tick_i;

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      pend   <= 1'b0;
      served <= 1'b0;
    end else if (!reqValid) begin
      // cycle over, ready for the next request
      pend   <= 1'b0;
      served <= 1'b0;
    end else if (tick_i) begin
      if (pend) begin
        pend   <= 1'b0;
        served <= 1'b1;
      end else if (!served) begin
        pend <= 1'b1;
      end
    end
  end

  // word write on the ack cycle
  always_ff @(posedge hwclk) begin
    if (ack_o && we_i) begin
      mem[wordIdx] <= dat_i;
    end
  end

  // read data captured when the request is first seen
  // stays put until the ack
  always_ff @(posedge hwclk) begin
    if (tick_i && reqValid && !pend && !served && !we_i) begin
      dat_o <= mem[wordIdx];
    end
  end

endmodule

//--- logic/spiShifter.sv
`timescale 1ns/10ps

module spiShifter (
  input  logic            hwclk,
  input  logic            reset,
  input  logic            tick_i,
  input  logic            load_i,
  input  wb_pkg::wbWord_t word_i,
  output logic            chipSelect_o,
  output logic            sclk_o,
  output logic            bitData_o,
  output logic            done_o
);
  import wb_pkg::*;
  import disp_pkg::*;

  wbWord_t   shiftReg;
  bitCount_t bitCnt;
  // word held until chip select goes high again
  logic      armed;
  // high half of the serial clock
  logic      phase;
  // all 32 bits clocked out
  logic      lastBit;
  // falling sclk edge, next bit moves up
  logic      shiftNow;

  assign lastBit   = (bitCnt == bitCount_t'($bits(wbWord_t)));
  assign shiftNow  = tick_i && !chipSelect_o && !lastBit && phase;
  // done in the same tick where chip select rises
  assign done_o    = tick_i && !chipSelect_o && lastBit;
  assign sclk_o    = phase;
  // msb first, quiet line outside the window
  assign bitData_o = !chipSelect_o && shiftReg[$bits(wbWord_t)-1];

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      armed        <= 1'b0;
      chipSelect_o <= 1'b1;
      phase        <= 1'b0;
      bitCnt       <= '0;
    end else if (load_i && !armed) begin
      // new word, window opens on the next tick
      armed  <= 1'b1;
      phase  <= 1'b0;
      bitCnt <= '0;
    end else if (tick_i && armed) begin
      if (chipSelect_o) begin
        chipSelect_o <= 1'b0;
      end else if (lastBit) begin
        // close the window
        chipSelect_o <= 1'b1;
        armed        <= 1'b0;
      end else if (!phase) begin
        phase <= 1'b1;
      end else begin
        phase  <= 1'b0;
        bitCnt <= bitCnt + 6'd1;
      end
    end
  end

  // payload shift register
  always_ff @(posedge hwclk) begin
    if (load_i && !armed) begin
      shiftReg <= word_i;
    end else if (shiftNow) begin
      shiftReg <= shiftReg << 1;
    end
  end

endmodule

//--- logic/frameEngine.sv
`timescale 1ns/10ps
`include "board_settings.svh"

module frameEngine (
  input  logic            hwclk,
  input  logic            reset,
  input  logic            tick_i,
  input  logic            start_i,
  input  logic            clear_i,
  input  logic            rxready_i,
  input  logic [7:0]      rxdata_i,
  input  logic            ack_i,
  input  wb_pkg::wbWord_t dat_i,
  output logic            cyc_o,
  output logic            stb_o,
  output logic            we_o,
  output wb_pkg::wbAddr_t adr_o,
  output wb_pkg::wbWord_t dat_o,
  output logic            load_o,
  output wb_pkg::wbWord_t word_o,
  input  logic            done_i,
  output logic            busy_o,
  output logic [7:0]      loadPtr_o
);
  import wb_pkg::*;
  import disp_pkg::*;

  // frame word index width
  localparam int FIDX_W = $clog2(`FRAME_WORDS);

  engState_t         state;
  // single byte holding slot
  logic              pending;
  logic [7:0]        pendByte;
  // partial word, big endian
  wbWord_t           packWord;
  logic [1:0]        byteCnt;
  // start button edge detect
  logic              startPrev;
  logic              startRise;
  logic [FIDX_W-1:0] wordIdx;
  logic              lastWord;
  logic              takeByte;

  assign startRise = start_i && !startPrev;
  assign lastWord  = (wordIdx == FIDX_W'(`FRAME_WORDS - 1));
  // drop bytes when the slot is full or a frame is running
  assign takeByte  = rxready_i && !pending && (state == IDLE) && !busy_o;

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      state     <= IDLE;
      pending   <= 1'b0;
      pendByte  <= '0;
      packWord  <= '0;
      byteCnt   <= '0;
      startPrev <= 1'b0;
      wordIdx   <= '0;
      cyc_o     <= 1'b0;
      stb_o     <= 1'b0;
      we_o      <= 1'b0;
      adr_o     <= '0;
      dat_o     <= '0;
      load_o    <= 1'b0;
      word_o    <= '0;
      busy_o    <= 1'b0;
      loadPtr_o <= '0;
    end else begin
      // load is a one cycle strobe
      load_o <= 1'b0;
      if (tick_i) begin
        startPrev <= start_i;
        case (state)
          IDLE: begin
            if (clear_i) begin
              // restart loading at word 0
              loadPtr_o <= '0;
              byteCnt   <= '0;
              packWord  <= '0;
              pending   <= 1'b0;
            end else if (startRise) begin
              // frames always replay from word 0
              wordIdx <= '0;
              adr_o   <= '0;
              we_o    <= 1'b0;
              cyc_o   <= 1'b1;
              stb_o   <= 1'b1;
              busy_o  <= 1'b1;
              state   <= READ;
            end else if (pending) begin
              pending  <= 1'b0;
              packWord <= {packWord[23:0], pendByte};
              byteCnt  <= byteCnt + 2'd1;
              if (byteCnt == 2'd3) begin
                // fourth byte completes the word
                dat_o <= {packWord[23:0], pendByte};
                adr_o <= wbAddr_t'(loadPtr_o) << 2;
                we_o  <= 1'b1;
                cyc_o <= 1'b1;
                stb_o <= 1'b1;
                state <= WRITE;
              end
            end
          end
          WRITE: begin
            if (ack_i) begin
              cyc_o     <= 1'b0;
              stb_o     <= 1'b0;
              we_o      <= 1'b0;
              loadPtr_o <= loadPtr_o + 8'd1;
              state     <= IDLE;
            end
          end
          READ: begin
            if (ack_i) begin
              // hand the word straight to the shifter
              cyc_o  <= 1'b0;
              stb_o  <= 1'b0;
              word_o <= dat_i;
              load_o <= 1'b1;
              state  <= SHIFT;
            end
          end
          SHIFT: begin
            if (done_i) begin
              if (lastWord) begin
                busy_o <= 1'b0;
                state  <= IDLE;
              end else begin
                state <= NEXT;
              end
            end
          end
          NEXT: begin
            // next word address, new read cycle
            wordIdx <= wordIdx + 1'b1;
            adr_o   <= wbAddr_t'(wordIdx + 1'b1) << 2;
            cyc_o   <= 1'b1;
            stb_o   <= 1'b1;
            state   <= READ;
          end
          default: state <= IDLE;
        endcase
      end
      // uart capture runs every hwclk cycle
      if (takeByte) begin
        pending  <= 1'b1;
        pendByte <= rxdata_i;
      end
    end
  end

endmodule

//--- logic/fpgaTop.sv
`timescale 1ns/10ps

module fpgaTop (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  input  logic [7:0]  rxdata,
  input  logic        rxready,
  output logic        rxclk
);
  import wb_pkg::*;

  // clock enable, one per 51 hwclk cycles
  logic    tick;
  // bus between engine and sram
  logic    cyc;
  logic    stb;
  logic    we;
  logic    ack;
  wbAddr_t adr;
  wbWord_t wrData;
  wbWord_t rdData;
  // engine to shifter
  logic    load;
  logic    done;
  wbWord_t spiWord;
  // tft pins and status
  logic    chipSelect;
  logic    sclk;
  logic    bitData;
  logic    busy;
  logic [7:0] loadPtr;

  clkDivider divider (.hwclk(hwclk), .reset(reset), .tick_o(tick));

  // pb[0] starts a frame, pb[1] clears loading
  frameEngine engine (
    .hwclk(hwclk), .reset(reset), .tick_i(tick),
    .start_i(pb[0]), .clear_i(pb[1]),
    .rxready_i(rxready), .rxdata_i(rxdata),
    .ack_i(ack), .dat_i(rdData),
    .cyc_o(cyc), .stb_o(stb), .we_o(we), .adr_o(adr), .dat_o(wrData),
    .load_o(load), .word_o(spiWord), .done_i(done),
    .busy_o(busy), .loadPtr_o(loadPtr)
  );

  sramWb sram (
    .hwclk(hwclk), .reset(reset), .tick_i(tick),
    .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(wrData),
    .ack_o(ack), .dat_o(rdData)
  );

  spiShifter spi (
    .hwclk(hwclk), .reset(reset), .tick_i(tick),
    .load_i(load), .word_i(spiWord),
    .chipSelect_o(chipSelect), .sclk_o(sclk), .bitData_o(bitData), .done_o(done)
  );

  // busy on right[7], tft pins on right[3:1]
  assign right = {busy, 3'b000, chipSelect, sclk, bitData, 1'b0};
  assign left  = loadPtr;
  assign rxclk = tick;

endmodule

//--- bench/fpgaTop_assert.sv
`timescale 1ns/10ps

module fpgaTop_assert (
  input logic hwclk,
  input logic reset,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic chipSelect_i,
  input logic sclk_i
);

  // per-property failure tallies
  int stbFails = 0;
  int ackFails = 0;
  int sclkFails = 0;

  // strobe stays up inside its cycle until the slave answers
  stbHeld: assert property (@(posedge hwclk) disable iff (!reset)
    (stb_i && !ack_i) |=> (stb_i && cyc_i))
    else begin
      $error("bus strobe or cycle dropped before acknowledge");
      stbFails++;
    end

  // slave answers only a live strobe
  ackWithStb: assert property (@(posedge hwclk) disable iff (!reset) ack_i |-> stb_i)
    else begin
      $error("bus acknowledge without strobe");
      ackFails++;
    end

  // serial clock parked low outside the chip select window
  sclkIdle: assert property (@(posedge hwclk) disable iff (!reset) chipSelect_i |-> !sclk_i)
    else begin
      $error("serial clock high while chip select is high");
      sclkFails++;
    end

endmodule

// bus and tft pins all meet in the board top
bind fpgaTop fpgaTop_assert checks (
  .hwclk(hwclk), .reset(reset), .cyc_i(cyc), .stb_i(stb), .ack_i(ack),
  .chipSelect_i(chipSelect), .sclk_i(sclk)
);

//--- bench/fpgaTop_tb.sv
`timescale 1ns/10ps
`include "board_settings.svh"

module fpgaTop_tb;

  // 10 MHz board clock
  localparam int CLK_NS = 100;
  localparam int TICK_CYCLES = `TICK_TERMINAL + 1;
  // run budget in ticks from frames, bytes at 5 ticks each and button presses
  localparam int FRAMES = 6;
  localparam int BYTES = 120;
  localparam int TICKS_PER_WORD = 70;
  localparam longint RUN_TICKS = FRAMES * `FRAME_WORDS * TICKS_PER_WORD + BYTES * 5 + 200;
  localparam longint WATCHDOG_NS = 2 * RUN_TICKS * TICK_CYCLES * CLK_NS;
  // single frame bound in hwclk cycles
  localparam int FRAME_LIMIT = 2 * `FRAME_WORDS * TICKS_PER_WORD * TICK_CYCLES;

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  rxdata;
  logic        rxready;
  logic        rxclk;

  // sram mirror plus packing state
  logic [31:0] modelMem [`SRAM_WORDS];
  logic [31:0] modelPart;
  int          modelBytes;
  logic [7:0]  modelPtr;

  // frame words still due on the spi pins
  logic [31:0] expectQ [$];
  int          windowCount;
  int          errorCount;
  int          failedTests;
  int          testErrors;

  // spi monitor
  logic        prevCs;
  logic        prevSclk;
  logic [31:0] rxWord;
  int          shiftBits;

  fpgaTop uut (
    .hwclk(hwclk), .reset(reset), .pb(pb), .left(left), .right(right),
    .rxdata(rxdata), .rxready(rxready), .rxclk(rxclk)
  );

  initial begin
    hwclk = 1'b0;
    forever #(CLK_NS / 2) hwclk = ~hwclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run hung, watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // rxclk mirrors tick so count edges where it was high
  task automatic waitTicks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge hwclk);
      if (rxclk) seen++;
    end
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    assert (actual === expected) else begin
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
      errorCount++;
    end
  endtask

  task automatic reportTest(input int num, input string name);
    if (errorCount > testErrors) begin
      failedTests++;
      $display("test %0d %s: failed", num, name);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  // one rxready strobe; model follows big endian packing
  task automatic sendByte(input logic [7:0] value, input bit accepted);
    @(posedge hwclk);
    rxdata  <= value;
    rxready <= 1'b1;
    @(posedge hwclk);
    rxready <= 1'b0;
    if (accepted) begin
      modelPart = {modelPart[23:0], value};
      modelBytes++;
      if (modelBytes == 4) begin
        modelMem[modelPtr] = modelPart;
        modelPtr++;
        modelBytes = 0;
      end
    end
    // leaves room for the packing tick and a bus write
    waitTicks(4);
  endtask

  task automatic loadWords(input int n);
    for (int i = 0; i < 4 * n; i++) begin
      sendByte(8'($urandom), 1'b1);
    end
  endtask

  task automatic pressButton(input logic [20:0] mask);
    @(posedge hwclk);
    pb <= pb | mask;
    waitTicks(2);
    pb <= pb & ~mask;
    waitTicks(2);
  endtask

  // pb[1] drops the pointer and any partial word
  task automatic clearLoading();
    pressButton(21'h2);
    modelPtr   = '0;
    modelBytes = 0;
    modelPart  = '0;
  endtask

  task automatic startFrame();
    for (int w = 0; w < `FRAME_WORDS; w++) begin
      expectQ.push_back(modelMem[8'(w)]);
    end
    pressButton(21'h1);
  endtask

  task automatic waitFrameEnd();
    int cycles;
    cycles = 0;
    while (right[7] !== 1'b0 && cycles < FRAME_LIMIT) begin
      @(posedge hwclk);
      cycles++;
    end
    if (cycles >= FRAME_LIMIT) begin
      $display("frame did not finish, busy stayed high for %0d cycles", cycles);
      errorCount++;
    end
    // monitor closes the last window a cycle later
    waitTicks(2);
    assert (expectQ.size() == 0) else begin
      $display("frame ended with %0d words never shifted out", expectQ.size());
      errorCount++;
      expectQ.delete();
    end
  endtask

  task automatic checkWindow();
    logic [31:0] expected;
    if (expectQ.size() == 0) begin
      $display("SPI word %0h shifted out with no frame expected", rxWord);
      errorCount++;
    end else begin
      expected = expectQ.pop_front();
      checkEqual(32'(shiftBits), 32'd32, "SPI bits in window");
      checkEqual(rxWord, expected, "SPI word");
    end
  endtask

  // sample pins as they stood before the edge
  always @(posedge hwclk) begin
    if (!reset) begin
      prevCs    = 1'b1;
      prevSclk  = 1'b0;
      shiftBits = 0;
      rxWord    = '0;
    end else begin
      if (prevCs && !right[3]) begin
        shiftBits = 0;
        rxWord    = '0;
      end
      // rising sclk inside the window
      if (!right[3] && right[2] && !prevSclk) begin
        rxWord = {rxWord[30:0], right[1]};
        shiftBits++;
      end
      if (!prevCs && right[3]) begin
        windowCount++;
        checkWindow();
      end
      prevCs   = right[3];
      prevSclk = right[2];
    end
  end

  initial begin
    int startWindows;
    int partial;
    int totalErrors;
    int relCycles;
    void'($urandom(32'h91216ebf));
    reset       = 1'b0;
    pb          = '0;
    rxdata      = '0;
    rxready     = 1'b0;
    modelPart   = '0;
    modelBytes  = 0;
    modelPtr    = '0;
    windowCount = 0;
    errorCount  = 0;
    failedTests = 0;
    foreach (modelMem[i]) modelMem[i] = '0;
    repeat (4) @(posedge hwclk);
    reset <= 1'b1;

    // idle pins before the first tick
    testErrors = errorCount;
    repeat (3) @(posedge hwclk);
    checkEqual(32'(right[3]), 32'd1, "chip select after reset");
    checkEqual(32'(right[2]), 32'd0, "sclk after reset");
    checkEqual(32'(right[7]), 32'd0, "busy after reset");
    checkEqual(32'(left), 32'd0, "load pointer after reset");
    checkEqual(32'({right[6:4], right[0]}), 32'd0, "unused right bits after reset");
    checkEqual(32'(rxclk), 32'd0, "rxclk before the first tick");
    // divider pulse is registered, seen one edge after it is set
    relCycles = 3;
    while (rxclk !== 1'b1 && relCycles < 2 * TICK_CYCLES) begin
      @(posedge hwclk);
      relCycles++;
    end
    checkEqual(32'(relCycles), 32'(TICK_CYCLES + 1), "edges from reset release to tick");
    @(posedge hwclk);
    checkEqual(32'(rxclk), 32'd0, "rxclk one cycle after the tick");
    reportTest(1, "reset values");

    testErrors = errorCount;
    clearLoading();
    loadWords(8);
    startFrame();
    waitFrameEnd();
    checkEqual(32'(left), 32'd8, "load pointer after first frame");
    reportTest(2, "load and replay");

    // frames restart at word 0 whatever the pointer
    testErrors = errorCount;
    loadWords(8);
    checkEqual(32'(left), 32'd16, "load pointer after 16 words");
    startFrame();
    waitFrameEnd();
    reportTest(3, "replay from word 0");

    testErrors = errorCount;
    clearLoading();
    loadWords(8);
    startFrame();
    repeat (4) begin
      checkEqual(32'(right[7]), 32'd1, "busy while sending dropped bytes");
      sendByte(8'($urandom), 1'b0);
    end
    waitFrameEnd();
    checkEqual(32'(left), 32'd8, "load pointer after dropped bytes");
    startFrame();
    waitFrameEnd();
    reportTest(4, "bytes dropped while busy");

    testErrors = errorCount;
    startWindows = windowCount;
    startFrame();
    repeat (3) pressButton(21'h1);
    waitFrameEnd();
    waitTicks(5);
    checkEqual(32'(windowCount - startWindows), 32'd8, "chip select windows per start");
    checkEqual(32'(right[7]), 32'd0, "busy after ignored presses");
    reportTest(5, "start ignored while busy");

    // partial group then clear so the next four bytes form word 0
    testErrors = errorCount;
    clearLoading();
    partial = $urandom_range(3, 1);
    repeat (partial) sendByte(8'($urandom), 1'b1);
    clearLoading();
    loadWords(1);
    checkEqual(32'(left), 32'd1, "load pointer after partial clear");
    startFrame();
    waitFrameEnd();
    reportTest(6, "partial word discarded");

    totalErrors = errorCount + uut.checks.stbFails + uut.checks.ackFails
                + uut.checks.sclkFails;
    $display("tests 6, failed %0d, errors %0d", failedTests, totalErrors);
    if (failedTests == 0 && totalErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/wb_pkg.sv
logic/disp_pkg.sv
logic/clkDivider.sv
logic/sramWb.sv
logic/spiShifter.sv
logic/frameEngine.sv
logic/fpgaTop.sv
bench/fpgaTop_assert.sv
bench/fpgaTop_tb.sv

//--- Makefile
# Verilator flow for the display feed testbench
TOP = fpgaTop_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

# fail message in the log, or no pass message, fails the target
run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
